/* logic/cu_config_pkg.sv */
// Configuration constants for the vertex compute-unit read arbiter
`default_nettype none

package cu_config_pkg;

	////////////////////
	// Compute units
	////////////////////

	// Keep this a power of two so the priority pointer wraps by overflow
	localparam int NUM_VERTEX_CU = 4;
	localparam int CU_ID_BITS = $clog2(NUM_VERTEX_CU);
	localparam int VERTEX_COUNT_BITS = 32;

	////////////////////
	// Command FIFO
	////////////////////

	localparam int READ_CMD_BUFFER_DEPTH = 16;
	// Room for the command the arbiter may still have in flight
	localparam int ALMOST_FULL_MARGIN = 2;

endpackage

`default_nettype wire

/* logic/cu_command_pkg.sv */
// Read command and response field definitions for the vertex CU arbiter
`default_nettype none

package cu_command_pkg;

	////////////////////
	// Command fields
	////////////////////

	localparam int ADDRESS_BITS = 32;

	// Which graph array a read command targets
	typedef enum logic [1:0] {
		INV_EDGE_ARRAY_DEST,
		READ_GRAPH_DATA,
		VERTEX_ARRAY
	} array_kind_e;

	////////////////////
	// Response fields
	////////////////////

	// Tag returned by memory with each read response
	localparam int TAG_BITS = 8;

endpackage

`default_nettype wire

/* logic/round_robin_arbiter.sv */
// Round-robin arbiter over CU read commands, stamps the winner id and pulses its ready
`default_nettype none
`timescale 1ns/1ps

module round_robin_arbiter (
	input  logic                                      clock,
	input  logic                                      rstn,
	input  logic                                      enabled,
	input  logic [cu_config_pkg::NUM_VERTEX_CU-1:0]   cmd_cu_valid,
	input  logic [cu_command_pkg::ADDRESS_BITS-1:0]   cmd_cu_address [0:cu_config_pkg::NUM_VERTEX_CU-1],
	input  cu_command_pkg::array_kind_e               cmd_cu_kind [0:cu_config_pkg::NUM_VERTEX_CU-1],
	output logic [cu_config_pkg::NUM_VERTEX_CU-1:0]   cmd_cu_ready,
	input  logic                                      stall,
	output logic                                      arb_valid,
	output logic [cu_command_pkg::ADDRESS_BITS-1:0]   arb_address,
	output cu_command_pkg::array_kind_e               arb_kind,
	output logic [cu_config_pkg::CU_ID_BITS-1:0]      arb_cu_id
);

	import cu_config_pkg::*;

	logic [NUM_VERTEX_CU-1:0] eligible;
	logic [CU_ID_BITS-1:0]    last_winner;
	logic [CU_ID_BITS-1:0]    pick;
	logic [CU_ID_BITS-1:0]    idx;
	logic                     found;
	logic                     take;

	// The CU pulsed last cycle still shows its old valid
	assign eligible = cmd_cu_valid & ~cmd_cu_ready;

	// First eligible CU after the last winner, the winner itself last
	always_comb begin
		found = 1'b0;
		pick  = last_winner;
		idx   = last_winner;
		for (int k = 1; k <= NUM_VERTEX_CU; k++) begin
			idx = last_winner + CU_ID_BITS'(k);
			if (!found && eligible[idx]) begin
				found = 1'b1;
				pick  = idx;
			end
		end
	end

	assign take = enabled && !stall && found;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			arb_valid    <= 1'b0;
			cmd_cu_ready <= '0;
			last_winner  <= CU_ID_BITS'(NUM_VERTEX_CU - 1);
		end else begin
			arb_valid    <= take;
			cmd_cu_ready <= take ? (NUM_VERTEX_CU'(1) << pick) : '0;
			if (take)
				last_winner <= pick;
		end
	end

	// Command payload
	always_ff @(posedge clock) begin
		if (take) begin
			arb_address <= cmd_cu_address[pick];
			arb_kind    <= cmd_cu_kind[pick];
			arb_cu_id   <= pick;
		end
	end

endmodule

`default_nettype wire

/* logic/read_command_buffer.sv */
// Burst FIFO for arbitrated read commands with bus request and grant handshake
`default_nettype none
`timescale 1ns/1ps

module read_command_buffer (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enabled,
	input  logic                                    push_valid,
	input  logic [cu_command_pkg::ADDRESS_BITS-1:0] push_address,
	input  cu_command_pkg::array_kind_e             push_kind,
	input  logic [cu_config_pkg::CU_ID_BITS-1:0]    push_cu_id,
	output logic                                    almost_full,
	input  logic                                    bus_almost_full,
	input  logic                                    bus_grant,
	output logic                                    bus_request,
	output logic                                    read_command_out_valid,
	output logic [cu_command_pkg::ADDRESS_BITS-1:0] read_command_out_address,
	output cu_command_pkg::array_kind_e             read_command_out_kind,
	output logic [cu_config_pkg::CU_ID_BITS-1:0]    read_command_out_cu_id
);

	import cu_config_pkg::*;
	import cu_command_pkg::*;

	logic [ADDRESS_BITS-1:0] mem_address [0:READ_CMD_BUFFER_DEPTH-1];
	array_kind_e             mem_kind    [0:READ_CMD_BUFFER_DEPTH-1];
	logic [CU_ID_BITS-1:0]   mem_cu_id   [0:READ_CMD_BUFFER_DEPTH-1];

	logic [$clog2(READ_CMD_BUFFER_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(READ_CMD_BUFFER_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(READ_CMD_BUFFER_DEPTH+1)-1:0] count;
	logic [$clog2(READ_CMD_BUFFER_DEPTH+1)-1:0] count_next;
	logic                                       empty;
	logic                                       pop;

	assign empty       = (count == '0);
	assign pop         = bus_grant && !empty;
	assign almost_full = (count >= READ_CMD_BUFFER_DEPTH - ALMOST_FULL_MARGIN);

	always_comb begin
		count_next = count;
		if (push_valid && !pop)
			count_next = count + 1'b1;
		else if (pop && !push_valid)
			count_next = count - 1'b1;
	end

	////////////////////
	// Pointers and bus handshake
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr                 <= '0;
			rd_ptr                 <= '0;
			count                  <= '0;
			bus_request            <= 1'b0;
			read_command_out_valid <= 1'b0;
		end else begin
			count                  <= count_next;
			// Request follows the occupancy left after this edge
			bus_request            <= enabled && (count_next != '0) && !bus_almost_full;
			read_command_out_valid <= pop;
			if (push_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage and output payload
	always_ff @(posedge clock) begin
		if (push_valid) begin
			mem_address[wr_ptr] <= push_address;
			mem_kind[wr_ptr]    <= push_kind;
			mem_cu_id[wr_ptr]   <= push_cu_id;
		end
		if (pop) begin
			read_command_out_address <= mem_address[rd_ptr];
			read_command_out_kind    <= mem_kind[rd_ptr];
			read_command_out_cu_id   <= mem_cu_id[rd_ptr];
		end
	end

endmodule

`default_nettype wire

/* logic/response_demux.sv */
// Steers a memory read response to the compute unit named by its cu id
`default_nettype none
`timescale 1ns/1ps

module response_demux (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  response_valid,
	input  logic [cu_config_pkg::CU_ID_BITS-1:0]  response_cu_id,
	input  logic [cu_command_pkg::TAG_BITS-1:0]   response_tag,
	output logic [cu_config_pkg::NUM_VERTEX_CU-1:0] response_cu_valid,
	output logic [cu_command_pkg::TAG_BITS-1:0]   response_cu_tag
);

	import cu_config_pkg::*;

	logic [NUM_VERTEX_CU-1:0] select;

	// One-hot decode of the target CU
	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++)
			select[i] = response_valid && (response_cu_id == CU_ID_BITS'(i));
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			response_cu_valid <= '0;
		else
			response_cu_valid <= select;
	end

	// Tag is shared, only the valid bit picks the CU
	always_ff @(posedge clock) begin
		response_cu_tag <= response_tag;
	end

endmodule

`default_nettype wire

/* logic/counter_sum_reduce.sv */
// Registered sum of the per-CU vertex counters into one completion count
`default_nettype none
`timescale 1ns/1ps

module counter_sum_reduce (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic                                        enabled,
	input  logic [cu_config_pkg::VERTEX_COUNT_BITS-1:0] vertex_count_cu [0:cu_config_pkg::NUM_VERTEX_CU-1],
	output logic [cu_config_pkg::VERTEX_COUNT_BITS-1:0] vertex_count_total
);

	import cu_config_pkg::*;

	logic [VERTEX_COUNT_BITS-1:0] sum;

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_VERTEX_CU; i++)
			sum = sum + vertex_count_cu[i];
	end

	// Holds the last total while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			vertex_count_total <= '0;
		else if (enabled)
			vertex_count_total <= sum;
	end

endmodule

`default_nettype wire

/* logic/cu_vertex_arbiter_control.sv */
// Vertex CU arbiter top: read command arbitration, burst buffer, response routing, count sum
`default_nettype none
`timescale 1ns/1ps

module cu_vertex_arbiter_control (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic                                        enabled_in,
	input  logic [cu_config_pkg::NUM_VERTEX_CU-1:0]     cmd_cu_valid,
	input  logic [cu_command_pkg::ADDRESS_BITS-1:0]     cmd_cu_address [0:cu_config_pkg::NUM_VERTEX_CU-1],
	input  cu_command_pkg::array_kind_e                 cmd_cu_kind [0:cu_config_pkg::NUM_VERTEX_CU-1],
	output logic [cu_config_pkg::NUM_VERTEX_CU-1:0]     cmd_cu_ready,
	input  logic                                        bus_almost_full,
	input  logic                                        bus_grant,
	output logic                                        bus_request,
	output logic                                        read_command_out_valid,
	output logic [cu_command_pkg::ADDRESS_BITS-1:0]     read_command_out_address,
	output cu_command_pkg::array_kind_e                 read_command_out_kind,
	output logic [cu_config_pkg::CU_ID_BITS-1:0]        read_command_out_cu_id,
	input  logic                                        response_valid,
	input  logic [cu_config_pkg::CU_ID_BITS-1:0]        response_cu_id,
	input  logic [cu_command_pkg::TAG_BITS-1:0]         response_tag,
	output logic [cu_config_pkg::NUM_VERTEX_CU-1:0]     response_cu_valid,
	output logic [cu_command_pkg::TAG_BITS-1:0]         response_cu_tag,
	input  logic [cu_config_pkg::VERTEX_COUNT_BITS-1:0] vertex_count_cu [0:cu_config_pkg::NUM_VERTEX_CU-1],
	output logic [cu_config_pkg::VERTEX_COUNT_BITS-1:0] vertex_count_total
);

	import cu_config_pkg::*;
	import cu_command_pkg::*;

	logic                    enabled;
	logic                    buffer_almost_full;
	logic                    arb_valid;
	logic [ADDRESS_BITS-1:0] arb_address;
	array_kind_e             arb_kind;
	logic [CU_ID_BITS-1:0]   arb_cu_id;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	////////////////////
	// Read command path
	////////////////////

	round_robin_arbiter arbiter (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.cmd_cu_valid  (cmd_cu_valid),
		.cmd_cu_address(cmd_cu_address),
		.cmd_cu_kind   (cmd_cu_kind),
		.cmd_cu_ready  (cmd_cu_ready),
		.stall         (buffer_almost_full),
		.arb_valid     (arb_valid),
		.arb_address   (arb_address),
		.arb_kind      (arb_kind),
		.arb_cu_id     (arb_cu_id)
	);

	read_command_buffer command_buffer (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled                 (enabled),
		.push_valid              (arb_valid),
		.push_address            (arb_address),
		.push_kind               (arb_kind),
		.push_cu_id              (arb_cu_id),
		.almost_full             (buffer_almost_full),
		.bus_almost_full         (bus_almost_full),
		.bus_grant               (bus_grant),
		.bus_request             (bus_request),
		.read_command_out_valid  (read_command_out_valid),
		.read_command_out_address(read_command_out_address),
		.read_command_out_kind   (read_command_out_kind),
		.read_command_out_cu_id  (read_command_out_cu_id)
	);

	////////////////////
	// Responses and completion count
	////////////////////

	response_demux demux (
		.clock            (clock),
		.rstn             (rstn),
		.response_valid   (response_valid),
		.response_cu_id   (response_cu_id),
		.response_tag     (response_tag),
		.response_cu_valid(response_cu_valid),
		.response_cu_tag  (response_cu_tag)
	);

	counter_sum_reduce vertex_sum (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.vertex_count_cu   (vertex_count_cu),
		.vertex_count_total(vertex_count_total)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset source, 20 ns period with a 10-cycle reset
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Release on a rising edge so the first active edge is clean
	initial begin
		rstn = 1'b0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/cu_vertex_arbiter_asserts.sv */
// Handshake assertions for the round-robin arbiter and the read command buffer
`default_nettype none
`timescale 1ns/1ps

module cu_vertex_arbiter_asserts (
	input logic                                    clock,
	input logic                                    rstn,
	input logic [cu_config_pkg::NUM_VERTEX_CU-1:0] cmd_cu_ready,
	input logic                                    stall,
	input logic                                    arb_valid,
	input logic                                    bus_grant,
	input logic                                    bus_request
);

	ready_one_hot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(cmd_cu_ready))
		else $error("cmd_cu_ready has more than one bit set");

	// Command register follows the stall by one edge
	no_take_while_stalled: assert property (@(posedge clock) disable iff (!rstn)
		stall |=> !arb_valid)
		else $error("command taken while the buffer was almost full");

	grant_needs_request: assert property (@(posedge clock) disable iff (!rstn)
		bus_grant |-> bus_request)
		else $error("bus_grant seen without bus_request");

endmodule

bind round_robin_arbiter cu_vertex_arbiter_asserts arbiter_asserts (
	.clock(clock), .rstn(rstn), .cmd_cu_ready(cmd_cu_ready), .stall(stall),
	.arb_valid(arb_valid), .bus_grant(1'b0), .bus_request(1'b0));

bind read_command_buffer cu_vertex_arbiter_asserts buffer_asserts (
	.clock(clock), .rstn(rstn), .cmd_cu_ready('0), .stall(almost_full),
	.arb_valid(push_valid), .bus_grant(bus_grant), .bus_request(bus_request));

`default_nettype wire

/* testbench/tb_cu_vertex_arbiter.sv */
// Table-driven testbench for the vertex CU arbiter with a bus model and reference checks
`default_nettype none
`timescale 1ns/1ps

module tb_cu_vertex_arbiter;

	import cu_config_pkg::*;
	import cu_command_pkg::*;

	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 100;

	// Per-CU fields are listed from the highest CU down to CU0
	typedef struct packed {
		logic [NUM_VERTEX_CU-1:0]                        mask;
		logic [NUM_VERTEX_CU-1:0][1:0]                   kind;
		logic                                            bus_full;
		logic [CU_ID_BITS-1:0]                           resp_id;
		logic [TAG_BITS-1:0]                             resp_tag;
		logic [NUM_VERTEX_CU-1:0][VERTEX_COUNT_BITS-1:0] count;
		logic [VERTEX_COUNT_BITS-1:0]                    total;
	} row_t;

	typedef struct packed {
		logic [ADDRESS_BITS-1:0] address;
		logic [1:0]              kind;
		logic [CU_ID_BITS-1:0]   cu_id;
	} cmd_t;

	logic clock;
	logic rstn;
	logic enabled_in;
	logic [NUM_VERTEX_CU-1:0] cmd_cu_valid;
	logic [ADDRESS_BITS-1:0] cmd_cu_address [0:NUM_VERTEX_CU-1];
	array_kind_e cmd_cu_kind [0:NUM_VERTEX_CU-1];
	logic [NUM_VERTEX_CU-1:0] cmd_cu_ready;
	logic bus_almost_full;
	logic bus_grant = 1'b0;
	logic bus_request;
	logic read_command_out_valid;
	logic [ADDRESS_BITS-1:0] read_command_out_address;
	array_kind_e read_command_out_kind;
	logic [CU_ID_BITS-1:0] read_command_out_cu_id;
	logic response_valid;
	logic [CU_ID_BITS-1:0] response_cu_id;
	logic [TAG_BITS-1:0] response_tag;
	logic [NUM_VERTEX_CU-1:0] response_cu_valid;
	logic [TAG_BITS-1:0] response_cu_tag;
	logic [VERTEX_COUNT_BITS-1:0] vertex_count_cu [0:NUM_VERTEX_CU-1];
	logic [VERTEX_COUNT_BITS-1:0] vertex_count_total;

	row_t table_rows [0:NUM_ROWS-1];
	cmd_t expect_q [$];
	logic [31:0] lfsr_state;
	int last_winner;
	int error_count;
	int cycle_count;

	tb_clock_gen clock_gen (.clock(clock), .rstn(rstn));

	cu_vertex_arbiter_control uut (
		.clock(clock), .rstn(rstn), .enabled_in(enabled_in),
		.cmd_cu_valid(cmd_cu_valid), .cmd_cu_address(cmd_cu_address),
		.cmd_cu_kind(cmd_cu_kind), .cmd_cu_ready(cmd_cu_ready),
		.bus_almost_full(bus_almost_full), .bus_grant(bus_grant), .bus_request(bus_request),
		.read_command_out_valid(read_command_out_valid),
		.read_command_out_address(read_command_out_address),
		.read_command_out_kind(read_command_out_kind),
		.read_command_out_cu_id(read_command_out_cu_id),
		.response_valid(response_valid), .response_cu_id(response_cu_id),
		.response_tag(response_tag), .response_cu_valid(response_cu_valid),
		.response_cu_tag(response_cu_tag),
		.vertex_count_cu(vertex_count_cu), .vertex_count_total(vertex_count_total)
	);

	// Bus model, grants each request with a gap after every grant
	always @(posedge clock)
		bus_grant <= rstn && bus_request && !bus_grant;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	task automatic compare_values(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Checks failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Galois LFSR x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	task automatic draw_bits(input int width, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < width; b++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Rotation rule: first waiting CU after the last winner
	function automatic logic [NUM_VERTEX_CU-1:0] expected_ready(
		input logic [NUM_VERTEX_CU-1:0] pending, input int last);
		int idx;
		for (int k = 1; k <= NUM_VERTEX_CU; k++) begin
			idx = (last + k) % NUM_VERTEX_CU;
			if (pending[idx])
				return NUM_VERTEX_CU'(1) << idx;
		end
		return '0;
	endfunction

	task automatic run_row(input int r);
		row_t row;
		cmd_t entry;
		logic [NUM_VERTEX_CU-1:0] pending;
		logic [ADDRESS_BITS-1:0] row_address [0:NUM_VERTEX_CU-1];
		logic full_now;
		int cyc;
		row = table_rows[r];
		pending = row.mask;
		full_now = row.bus_full;
		cyc = 0;
		for (int c = 0; c < NUM_VERTEX_CU; c++) begin
			draw_bits(ADDRESS_BITS, row_address[c]);
			cmd_cu_address[c] <= row_address[c];
			cmd_cu_kind[c] <= array_kind_e'(row.kind[c]);
			vertex_count_cu[c] <= row.count[c];
		end
		cmd_cu_valid <= row.mask;
		bus_almost_full <= row.bus_full;
		response_valid <= 1'b1;
		response_cu_id <= row.resp_id;
		response_tag <= row.resp_tag;
		while (cyc < 4 || pending != '0 || expect_q.size() != 0 || full_now) begin
			@(posedge clock);
			cyc++;
			if (cyc == 1)
				response_valid <= 1'b0;
			if (cyc == 2) begin
				compare_values("response_cu_valid", response_cu_valid,
					NUM_VERTEX_CU'(1) << row.resp_id);
				compare_values("response_cu_tag", response_cu_tag, row.resp_tag);
				compare_values("vertex_count_total", vertex_count_total, row.total);
			end
			if (cyc == 3)
				compare_values("response_cu_valid after pulse", response_cu_valid, 0);
			if (cmd_cu_ready != '0) begin
				compare_values("cmd_cu_ready", cmd_cu_ready, expected_ready(pending, last_winner));
				for (int c = 0; c < NUM_VERTEX_CU; c++) begin
					if (cmd_cu_ready[c]) begin
						pending[c] = 1'b0;
						last_winner = c;
						cmd_cu_valid[c] <= 1'b0;
						entry.address = row_address[c];
						entry.kind = row.kind[c];
						entry.cu_id = CU_ID_BITS'(c);
						expect_q.push_back(entry);
					end
				end
			end
			if (read_command_out_valid) begin
				compare_values("output while bus_almost_full", full_now, 1'b0);
				compare_values("output with no command waiting", expect_q.size() == 0, 1'b0);
				entry = expect_q.pop_front();
				compare_values("read_command_out_address", read_command_out_address, entry.address);
				compare_values("read_command_out_kind", read_command_out_kind, entry.kind);
				compare_values("read_command_out_cu_id", read_command_out_cu_id, entry.cu_id);
			end
			if (full_now && pending == '0 && cyc >= 12) begin
				full_now = 1'b0;
				bus_almost_full <= 1'b0;
			end
		end
		// Last accepted command is out, so the FIFO must be empty
		compare_values("bus_request with no command left", bus_request, 1'b0);
	endtask

	initial begin
		enabled_in = 1'b0;
		cmd_cu_valid = '0;
		bus_almost_full = 1'b0;
		response_valid = 1'b0;
		response_cu_id = '0;
		response_tag = '0;
		for (int c = 0; c < NUM_VERTEX_CU; c++) begin
			cmd_cu_address[c] = '0;
			cmd_cu_kind[c] = INV_EDGE_ARRAY_DEST;
			vertex_count_cu[c] = '0;
		end
		lfsr_state = 32'd99;
		last_winner = 0;
		error_count = 0;
		cycle_count = 0;

		////////////////////
		// Stimulus table
		////////////////////
		table_rows[0] = '{4'b0001, {INV_EDGE_ARRAY_DEST, INV_EDGE_ARRAY_DEST,
			INV_EDGE_ARRAY_DEST, VERTEX_ARRAY}, 1'b0, 2'd0, 8'h11,
			{32'd4, 32'd3, 32'd2, 32'd1}, 32'd10};
		table_rows[1] = '{4'b0100, {INV_EDGE_ARRAY_DEST, READ_GRAPH_DATA,
			INV_EDGE_ARRAY_DEST, INV_EDGE_ARRAY_DEST}, 1'b0, 2'd3, 8'ha5,
			{32'd40, 32'd30, 32'd20, 32'd10}, 32'd100};
		table_rows[2] = '{4'b1111, {VERTEX_ARRAY, READ_GRAPH_DATA,
			INV_EDGE_ARRAY_DEST, VERTEX_ARRAY}, 1'b0, 2'd1, 8'h3c,
			{32'd400, 32'd300, 32'd200, 32'd100}, 32'd1000};
		table_rows[3] = '{4'b1111, {INV_EDGE_ARRAY_DEST, VERTEX_ARRAY,
			READ_GRAPH_DATA, READ_GRAPH_DATA}, 1'b1, 2'd2, 8'hf0,
			{32'h1000, 32'h0, 32'h0, 32'h0234}, 32'h1234};
		table_rows[4] = '{4'b1011, {READ_GRAPH_DATA, INV_EDGE_ARRAY_DEST,
			VERTEX_ARRAY, INV_EDGE_ARRAY_DEST}, 1'b0, 2'd3, 8'h5e,
			{32'd7, 32'd7, 32'd7, 32'd7}, 32'd28};
		table_rows[5] = '{4'b0110, {INV_EDGE_ARRAY_DEST, VERTEX_ARRAY,
			READ_GRAPH_DATA, INV_EDGE_ARRAY_DEST}, 1'b1, 2'd0, 8'h81,
			{32'd0, 32'd0, 32'd0, 32'd0}, 32'd0};
		// Sum wraps at the counter width
		table_rows[6] = '{4'b1111, {READ_GRAPH_DATA, READ_GRAPH_DATA,
			VERTEX_ARRAY, INV_EDGE_ARRAY_DEST}, 1'b0, 2'd2, 8'hc3,
			{32'hffff_ffff, 32'd1, 32'd5, 32'd0}, 32'd5};
		table_rows[7] = '{4'b1000, {VERTEX_ARRAY, INV_EDGE_ARRAY_DEST,
			INV_EDGE_ARRAY_DEST, INV_EDGE_ARRAY_DEST}, 1'b0, 2'd1, 8'h09,
			{32'd1000, 32'd2000, 32'd3000, 32'd4000}, 32'd10000};

		@(posedge rstn);
		@(posedge clock);
		compare_values("cmd_cu_ready after reset", cmd_cu_ready, 0);
		compare_values("bus_request after reset", bus_request, 0);
		compare_values("read_command_out_valid after reset", read_command_out_valid, 0);
		compare_values("response_cu_valid after reset", response_cu_valid, 0);
		compare_values("vertex_count_total after reset", vertex_count_total, 0);
		enabled_in <= 1'b1;
		@(posedge clock);

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		if (error_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "Mismatches were found");
		end
	end

endmodule

`default_nettype wire

/* compile.f */
logic/cu_config_pkg.sv
logic/cu_command_pkg.sv
logic/round_robin_arbiter.sv
logic/read_command_buffer.sv
logic/response_demux.sv
logic/counter_sum_reduce.sv
logic/cu_vertex_arbiter_control.sv
testbench/tb_clock_gen.sv
testbench/cu_vertex_arbiter_asserts.sv
testbench/tb_cu_vertex_arbiter.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_cu_vertex_arbiter -o tb_sim || exit 1
sim_output=$(./obj_dir/tb_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "All checks passed" && exit 0 || exit 1
